// ==== all.f ====
verilog/hasti_pkg.sv
verilog/hasti_converter.sv
verilog/mem_arbiter.sv
verilog/sram_bytemask.sv
verilog/hasti_mem_top.sv
verif/tb_hasti_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the two-port memory testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  --timescale 1ns/10ps \
  --top-module tb_hasti_mem \
  -f all.f \
  -o sim_hasti_mem

# A failing run exits non-zero, the log search below gives the verdict
./obj_dir/sim_hasti_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

// ==== verif/tb_hasti_mem.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_hasti_mem;

  logic                                   clk_i;
  logic                                   reset_i;
  hasti_pkg::hasti_addr_s [1:0]           ahb_addr;
  logic [1:0][hasti_pkg::hdata_width-1:0] hwdata;
  logic [1:0][hasti_pkg::hdata_width-1:0] hrdata;
  logic [1:0]                             hready;
  hasti_pkg::hresp_e [1:0]                hresp;

  logic [31:0] model_mem [0:(2**hasti_pkg::mem_addr_width)-1];
  int          seed = 32'hd6e2_fd2f;
  int          cycle_cnt = 0;
  int          max_cycles = 2000; // About 500 cycles of traffic, four times that as margin
  logic        rr_expect = 1'b0;  // Port that should win the next tie
  string       test_name = "reset";

  hasti_mem_top dut0
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .addr_i   (ahb_addr),
      .hwdata_i (hwdata),
      .hrdata_o (hrdata),
      .hready_o (hready),
      .hresp_o  (hresp)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
    begin
      $display("Timeout in %s after %0d cycles, a transfer never completed",
               test_name, cycle_cnt);
      $display("Test failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic check_value
    (
      input string       test,
      input logic [31:0] expected,
      input logic [31:0] actual
    );
    if (expected !== actual)
    begin
      $display("[FAIL] %s expected %08h actual %08h", test, expected, actual);
      $display("Test failed");
      $fatal(1, "Mismatch in %s", test);
    end
  endtask

  function automatic hasti_pkg::hasti_addr_s idle_phase();
    return '{haddr: '0, hwrite: 1'b0, hsize: hasti_pkg::WORD, htrans: hasti_pkg::IDLE};
  endfunction

  // A narrow transfer uses the byte lanes picked by its low address bits
  function automatic logic [3:0] lane_mask(input hasti_pkg::hsize_e size,
                                           input logic [1:0] offset);
    logic [3:0] lanes;
    case (size)
      hasti_pkg::BYTE: lanes = 4'b0001;
      hasti_pkg::HALF: lanes = 4'b0011;
      default:         lanes = 4'b1111;
    endcase
    return lanes << offset;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input hasti_pkg::hsize_e size,
                                      input logic [31:0] data);
    logic [3:0] lanes;
    lanes = lane_mask(size, addr[1:0]);
    for (int b = 0; b < 4; b++)
    begin
      if (lanes[b])
      begin
        model_mem[addr[hasti_pkg::mem_addr_width+1:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    return model_mem[addr[hasti_pkg::mem_addr_width+1:2]]; // Upper address bits wrap
  endfunction

  // One single transfer on each port selected by act, both started in the same cycle
  task automatic run_xfer
    (
      input  logic [1:0]              act,
      input  logic [1:0]              wr,
      input  logic [1:0][31:0]        addr,
      input  hasti_pkg::hsize_e [1:0] size,
      input  logic [1:0][31:0]        wdata,
      output logic [1:0][31:0]        rdata,
      output logic [1:0][7:0]         lat
    );
    logic [1:0] done;
    @(posedge clk_i);
    #1;
    for (int p = 0; p < 2; p++)
    begin
      if (act[p])
      begin
        ahb_addr[p] = '{haddr: addr[p], hwrite: wr[p], hsize: size[p],
                        htrans: hasti_pkg::NONSEQ};
      end
    end
    @(posedge clk_i);
    #1;
    for (int p = 0; p < 2; p++)
    begin
      if (act[p])
      begin
        ahb_addr[p] = idle_phase();
        hwdata[p]   = wdata[p]; // Held for the whole data phase
      end
    end
    done  = ~act;
    lat   = '0;
    rdata = '0;
    while (done != 2'b11)
    begin
      @(negedge clk_i);
      for (int p = 0; p < 2; p++)
      begin
        if (!done[p])
        begin
          lat[p] = lat[p] + 8'd1;
          if (hready[p])
          begin
            done[p]  = 1'b1;
            rdata[p] = hrdata[p];
            check_value({test_name, " hresp"}, 32'(hasti_pkg::OKAY), 32'(hresp[p]));
            if (wr[p])
            begin
              model_write(addr[p], size[p], wdata[p]);
            end
          end
        end
      end
    end
  endtask

  task automatic ahb_write
    (
      input  logic              port,
      input  logic [31:0]       addr,
      input  hasti_pkg::hsize_e size,
      input  logic [31:0]       data,
      output logic [7:0]        lat
    );
    hasti_pkg::hsize_e [1:0] s;
    logic [1:0][31:0]        r;
    logic [1:0][7:0]         l;
    s[0] = size;
    s[1] = size;
    run_xfer(2'b01 << port, 2'b11, {addr, addr}, s, {data, data}, r, l);
    lat = l[port];
  endtask

  task automatic ahb_read
    (
      input  logic        port,
      input  logic [31:0] addr,
      output logic [31:0] data,
      output logic [7:0]  lat
    );
    hasti_pkg::hsize_e [1:0] s;
    logic [1:0][31:0]        r;
    logic [1:0][7:0]         l;
    s[0] = hasti_pkg::WORD;
    s[1] = hasti_pkg::WORD;
    run_xfer(2'b01 << port, 2'b00, {addr, addr}, s, '0, r, l);
    data = r[port];
    lat  = l[port];
  endtask

  task automatic test_word_rw();
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    logic [7:0]  lat;
    test_name = "word_rw";
    for (int i = 0; i < 8; i++)
    begin
      a      = $random(seed);
      a[1:0] = 2'b00;
      d      = $random(seed);
      ahb_write(1'b1, a, hasti_pkg::WORD, d, lat);
      check_value("word_rw write latency", 32'd1, 32'(lat));
      ahb_read(1'b1, a, r, lat);
      check_value("word_rw read latency", 32'd2, 32'(lat));
      check_value("word_rw data", d, r);
    end
  endtask

  task automatic test_sub_word();
    logic [31:0] a;
    logic [31:0] r;
    logic [7:0]  lat;
    test_name = "sub_word";
    for (int i = 0; i < 2; i++)
    begin
      a      = $random(seed);
      a[1:0] = 2'b00;
      ahb_write(1'b1, a, hasti_pkg::WORD, $random(seed), lat);
      for (int off = 0; off < 4; off++)
      begin
        ahb_write(1'b1, a | 32'(off), hasti_pkg::BYTE, $random(seed), lat);
        ahb_read(1'b1, a, r, lat);
        check_value("sub_word byte", model_read(a), r);
      end
      for (int off = 0; off < 4; off += 2)
      begin
        ahb_write(1'b1, a | 32'(off), hasti_pkg::HALF, $random(seed), lat);
        ahb_read(1'b1, a, r, lat);
        check_value("sub_word half", model_read(a), r);
      end
    end
  endtask

  task automatic test_contention();
    logic [1:0][31:0]        a;
    logic [1:0][31:0]        d;
    logic [1:0][31:0]        r;
    logic [1:0][7:0]         lat;
    hasti_pkg::hsize_e [1:0] s;
    logic                    loser;
    test_name = "contention";
    s[0]      = hasti_pkg::WORD;
    s[1]      = hasti_pkg::WORD;
    for (int i = 0; i < 16; i++)
    begin
      a[0]      = $random(seed);
      a[0][1:0] = 2'b00;
      a[1]      = a[0] ^ 32'h0000_0800; // Another word of the same SRAM
      d[0]      = $random(seed);
      d[1]      = $random(seed);
      loser     = ~rr_expect;
      run_xfer(2'b11, 2'b11, a, s, d, r, lat);
      check_value("contention write winner latency", 32'd1, 32'(lat[rr_expect]));
      check_value("contention write loser latency", 32'd2, 32'(lat[loser]));
      rr_expect = loser;
      loser     = ~rr_expect;
      // Each port reads the word the other one wrote
      run_xfer(2'b11, 2'b00, {a[0], a[1]}, s, d, r, lat);
      check_value("contention read winner latency", 32'd2, 32'(lat[rr_expect]));
      check_value("contention read loser latency", 32'd3, 32'(lat[loser]));
      rr_expect = loser;
      check_value("contention read port 0", model_read(a[1]), r[0]);
      check_value("contention read port 1", model_read(a[0]), r[1]);
    end
  endtask

  task automatic test_idle_busy();
    logic [31:0]        a;
    logic [31:0]        d;
    logic [31:0]        r;
    logic [7:0]         lat;
    hasti_pkg::htrans_e t0;
    hasti_pkg::htrans_e t1;
    test_name = "idle_busy";
    a         = $random(seed);
    a[1:0]    = 2'b00;
    d         = $random(seed);
    ahb_write(1'b1, a, hasti_pkg::WORD, d, lat);
    for (int v = 0; v < 2; v++)
    begin
      t0 = (v == 0) ? hasti_pkg::IDLE : hasti_pkg::BUSY;
      t1 = (v == 0) ? hasti_pkg::BUSY : hasti_pkg::IDLE;
      @(posedge clk_i);
      #1;
      ahb_addr[0] = '{haddr: a, hwrite: 1'b1, hsize: hasti_pkg::WORD, htrans: t0};
      ahb_addr[1] = '{haddr: a, hwrite: 1'b1, hsize: hasti_pkg::WORD, htrans: t1};
      hwdata[0]   = ~d;
      hwdata[1]   = ~d;
      repeat (3)
      begin
        @(negedge clk_i);
        check_value("idle_busy hready", 32'd0, 32'(hready));
      end
      @(posedge clk_i);
      #1;
      ahb_addr[0] = idle_phase();
      ahb_addr[1] = idle_phase();
    end
    ahb_read(1'b1, a, r, lat);
    check_value("idle_busy port 1 data", d, r);
    ahb_read(1'b0, a, r, lat);
    check_value("idle_busy port 0 data", d, r);
  endtask

  task automatic test_shared();
    logic [31:0] a;
    logic [31:0] r;
    logic [7:0]  lat;
    test_name = "shared";
    for (int i = 0; i < 8; i++)
    begin
      a      = $random(seed);
      a[1:0] = 2'b00;
      ahb_write(1'b1, a, hasti_pkg::WORD, $random(seed), lat);
      ahb_read(1'b0, a, r, lat);
      check_value("shared port 0 read latency", 32'd2, 32'(lat));
      check_value("shared port 0 data", model_read(a), r);
      ahb_write(1'b0, a | 32'd2, hasti_pkg::HALF, $random(seed), lat);
      ahb_read(1'b1, a, r, lat);
      check_value("shared port 1 data", model_read(a), r);
    end
  endtask

  initial
  begin
    reset_i     = 1'b1;
    ahb_addr[0] = idle_phase();
    ahb_addr[1] = idle_phase();
    hwdata      = '0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("reset hready", 32'd0, 32'(hready));
    test_word_rw();
    test_sub_word();
    test_contention();
    test_idle_busy();
    test_shared();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/hasti_converter.sv ====
`default_nettype none
`timescale 1ns/10ps

module hasti_converter
  (
    input  logic                                             clk_i,
    input  logic                                             reset_i,

    // AHB-Lite side, one channel per port
    input  hasti_pkg::hasti_addr_s [1:0]                     addr_i,
    input  logic [1:0][hasti_pkg::hdata_width-1:0]           hwdata_i,
    output logic [1:0][hasti_pkg::hdata_width-1:0]           hrdata_o,
    output logic [1:0]                                       hready_o,
    output hasti_pkg::hresp_e [1:0]                          hresp_o,

    // Memory side
    output hasti_pkg::mem_req_s [1:0]                        m_req_o,
    input  logic [1:0]                                       m_yumi_i,
    input  hasti_pkg::mem_rsp_s [1:0]                        m_rsp_i
  );

  for (genvar i = 0; i < 2; i++)
  begin : g_chan
    logic [hasti_pkg::haddr_width-1:0]  addr_r;
    hasti_pkg::hsize_e                  size_r;
    logic                               w_r;
    logic                               rd_pend_r;
    logic                               notrans_r;
    logic                               done;
    logic                               reload;
    logic [hasti_pkg::hdata_nbytes-1:0] lanes;

    // A write ends with its acceptance, a read with its response
    assign done   = w_r ? m_yumi_i[i] : m_rsp_i[i].v;
    assign reload = notrans_r | done;

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        w_r       <= 1'b0;
        rd_pend_r <= 1'b0;
        notrans_r <= 1'b1;
      end
      else if (reload)
      begin
        w_r       <= addr_i[i].hwrite;
        rd_pend_r <= ~addr_i[i].hwrite;
        notrans_r <= (addr_i[i].htrans != hasti_pkg::NONSEQ);
      end
      else if (m_yumi_i[i])
      begin
        rd_pend_r <= 1'b0; // Read is in memory now, wait for the data
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (reload)
      begin
        addr_r <= addr_i[i].haddr;
        size_r <= addr_i[i].hsize;
      end
    end

    always_comb
    begin
      case (size_r)
        hasti_pkg::BYTE: lanes = hasti_pkg::hdata_nbytes'(4'b0001);
        hasti_pkg::HALF: lanes = hasti_pkg::hdata_nbytes'(4'b0011);
        default:         lanes = hasti_pkg::hdata_nbytes'(4'b1111);
      endcase
    end

    assign m_req_o[i].v    = ~notrans_r & (w_r | rd_pend_r);
    assign m_req_o[i].w    = w_r;
    assign m_req_o[i].addr = addr_r;
    assign m_req_o[i].data = hwdata_i[i]; // Data phase word arrives a cycle after its address
    assign m_req_o[i].mask = ~(lanes << addr_r[1:0]);

    assign hrdata_o[i] = m_rsp_i[i].data;
    assign hready_o[i] = done;
    assign hresp_o[i]  = hasti_pkg::OKAY;
  end

endmodule

`default_nettype wire

// ==== verilog/hasti_mem_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module hasti_mem_top
  (
    input  logic                                   clk_i,
    input  logic                                   reset_i,

    // Port 0 is the instruction side, port 1 the data side
    input  hasti_pkg::hasti_addr_s [1:0]           addr_i,
    input  logic [1:0][hasti_pkg::hdata_width-1:0] hwdata_i,
    output logic [1:0][hasti_pkg::hdata_width-1:0] hrdata_o,
    output logic [1:0]                             hready_o,
    output hasti_pkg::hresp_e [1:0]                hresp_o
  );

  hasti_pkg::mem_req_s [1:0] mem_req;
  hasti_pkg::mem_rsp_s [1:0] mem_rsp;
  logic [1:0]                yumi;

  hasti_pkg::mem_req_s       sram_req;
  hasti_pkg::mem_rsp_s       sram_rsp;
  logic                      sram_port;
  logic                      sram_rsp_port;

  hasti_converter conv0
    (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .addr_i   (addr_i),
      .hwdata_i (hwdata_i),
      .hrdata_o (hrdata_o),
      .hready_o (hready_o),
      .hresp_o  (hresp_o),
      .m_req_o  (mem_req),
      .m_yumi_i (yumi),
      .m_rsp_i  (mem_rsp)
    );

  mem_arbiter arb0
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .req_i           (mem_req),
      .yumi_o          (yumi),
      .rsp_o           (mem_rsp),
      .sram_req_o      (sram_req),
      .sram_port_o     (sram_port),
      .sram_rsp_i      (sram_rsp),
      .sram_rsp_port_i (sram_rsp_port)
    );

  // Single shared array for both ports
  sram_bytemask sram0
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (sram_req),
      .port_i  (sram_port),
      .rsp_o   (sram_rsp),
      .port_o  (sram_rsp_port)
    );

endmodule

`default_nettype wire

// ==== verilog/hasti_pkg.sv ====
`default_nettype none

package hasti_pkg;

  localparam int haddr_width    = 32;
  localparam int hdata_width    = 32;
  localparam int hdata_nbytes   = hdata_width / 8;
  localparam int mem_addr_width = 10; // Word address bits, 1024 words

  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0]
  {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  typedef enum logic
  {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // Address phase as driven by one AHB-Lite master
  typedef struct packed
  {
    logic [haddr_width-1:0] haddr;
    logic                   hwrite;
    hsize_e                 hsize;
    htrans_e                htrans;
  } hasti_addr_s;

  // Mask bits are active low, a 1 leaves the byte untouched
  typedef struct packed
  {
    logic                    v;
    logic                    w;
    logic [haddr_width-1:0]  addr;
    logic [hdata_width-1:0]  data;
    logic [hdata_nbytes-1:0] mask;
  } mem_req_s;

  typedef struct packed
  {
    logic                   v;
    logic [hdata_width-1:0] data;
  } mem_rsp_s;

endpackage

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/10ps

module mem_arbiter
  (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // Requesters
    input  hasti_pkg::mem_req_s [1:0]     req_i,
    output logic [1:0]                    yumi_o,
    output hasti_pkg::mem_rsp_s [1:0]     rsp_o,

    // Shared memory
    output hasti_pkg::mem_req_s           sram_req_o,
    output logic                          sram_port_o,
    input  hasti_pkg::mem_rsp_s           sram_rsp_i,
    input  logic                          sram_rsp_port_i
  );

  logic rr_r; // Port that wins the next tie
  logic contend;
  logic grant0;
  logic grant1;

  assign contend = req_i[0].v & req_i[1].v;

  // Grant is combinational, so a lone request is taken in its first cycle
  assign grant1 = req_i[1].v & (~req_i[0].v | rr_r);
  assign grant0 = req_i[0].v & ~grant1;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rr_r <= 1'b0;
    end
    else if (contend)
    begin
      rr_r <= ~rr_r; // Loser of this tie wins the next one
    end
  end

  assign yumi_o[0] = grant0;
  assign yumi_o[1] = grant1;

  always_comb
  begin
    sram_req_o   = grant1 ? req_i[1] : req_i[0];
    sram_req_o.v = grant0 | grant1;
  end

  assign sram_port_o = grant1;

  // Read data goes to both ports, only the owner sees it valid
  for (genvar p = 0; p < 2; p++)
  begin : g_rsp
    assign rsp_o[p].v    = sram_rsp_i.v & (sram_rsp_port_i == 1'(p));
    assign rsp_o[p].data = sram_rsp_i.data;
  end

endmodule

`default_nettype wire

// ==== verilog/sram_bytemask.sv ====
`default_nettype none
`timescale 1ns/10ps

module sram_bytemask
  (
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  hasti_pkg::mem_req_s  req_i,
    input  logic                 port_i,

    output hasti_pkg::mem_rsp_s  rsp_o,
    output logic                 port_o
  );

  logic [hasti_pkg::hdata_width-1:0]    mem_r [0:(2**hasti_pkg::mem_addr_width)-1];
  logic [hasti_pkg::mem_addr_width-1:0] idx;
  logic [hasti_pkg::hdata_width-1:0]    rd_data_r;
  logic                                 rd_v_r;
  logic                                 port_r;

  // Byte address to word index, upper bits wrap
  assign idx = req_i.addr[hasti_pkg::mem_addr_width+1:2];

  always_ff @(posedge clk_i)
  begin
    if (req_i.v & req_i.w)
    begin
      for (int b = 0; b < hasti_pkg::hdata_nbytes; b++)
      begin
        if (!req_i.mask[b])
        begin
          mem_r[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_i.v & ~req_i.w)
    begin
      rd_data_r <= mem_r[idx];
      port_r    <= port_i; // Tells the arbiter where the data belongs
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_v_r <= 1'b0;
    end
    else
    begin
      rd_v_r <= req_i.v & ~req_i.w;
    end
  end

  assign rsp_o.v    = rd_v_r;
  assign rsp_o.data = rd_data_r;
  assign port_o     = port_r;

endmodule

`default_nettype wire
